//--- verilog/idu_macros.svh
// Decode stage widths
`ifndef IDU_MACROS_SVH
`define IDU_MACROS_SVH

// datapath and pc width
`define IDU_XLEN 64

// raw instruction width
`define IDU_ILEN 32

// general register addressing
`define IDU_REG_ADDR_W 5
`define IDU_NUM_REGS 32

`endif

//--- verilog/idu_pkg.sv
// Decode stage types
`include "idu_macros.svh"

package idu_pkg;

  typedef logic [`IDU_XLEN-1:0] xlen_t;
  typedef logic [`IDU_ILEN-1:0] inst_t;
  typedef logic [`IDU_REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,
    ALU_SLTU     = 5'd3,
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_MUL      = 5'd10,
    ALU_DIV      = 5'd11,
    ALU_DIVU     = 5'd12,
    ALU_REM      = 5'd13,
    ALU_REMU     = 5'd14,
    ALU_COPY_IMM = 5'd15, // lui
    ALU_MULH     = 5'd25,
    ALU_MULHSU   = 5'd26,
    ALU_MULHU    = 5'd27,
    ALU_INVALID  = 5'd31
  } alu_op_e;

  // stores reuse the signed codes
  typedef enum logic [2:0] {
    MEM_LB   = 3'd0,
    MEM_LBU  = 3'd1,
    MEM_LH   = 3'd2,
    MEM_LHU  = 3'd3,
    MEM_LW   = 3'd4,
    MEM_LWU  = 3'd5,
    MEM_LD   = 3'd6,
    MEM_NONE = 3'd7
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_JAL  = 3'd0,
    BR_JALR = 3'd1,
    BR_BEQ  = 3'd2,
    BR_BNE  = 3'd3,
    BR_BLT  = 3'd4,
    BR_BGE  = 3'd5,
    BR_BLTU = 3'd6,
    BR_BGEU = 3'd7
  } br_func_e;

  typedef enum logic [1:0] {
    ALU_B_RS2  = 2'd0,
    ALU_B_IMM  = 2'd1,
    ALU_B_FOUR = 2'd2 // link address pc + 4
  } alu_b_src_e;

  typedef enum logic [2:0] {
    IMM_I    = 3'd0,
    IMM_U    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_J    = 3'd4,
    IMM_NONE = 3'd7
  } imm_fmt_e;

  typedef struct packed {
    inst_t inst;
    xlen_t pc;
  } fetch_t;

  typedef struct packed {
    reg_addr_t  rd;
    xlen_t      imm;
    logic       alu_a_src; // 1 selects pc
    alu_b_src_e alu_b_src;
    alu_op_e    alu_op;
    logic       word_cut;
    logic       reg_wr;
    logic       mem_to_reg;
    logic       mem_wr;
    logic       mem_re;
    mem_op_e    mem_op;
    logic       br_en;
    br_func_e   br_func;
    logic       invalid;
  } dec_ctrl_t;

  typedef struct packed {
    logic      wen;
    reg_addr_t waddr;
    xlen_t     wdata;
  } wb_t;

endpackage

//--- verilog/idu_inst_reg.sv
// Decode register
`timescale 1ns/1ps

module idu_inst_reg (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_fetch_valid,
  input  idu_pkg::fetch_t  i_fetch,
  output logic             o_fetch_ready,
  output logic             o_valid,
  input  logic             i_ready,
  output idu_pkg::fetch_t  o_fetch
);

  logic            valid_q;
  idu_pkg::fetch_t fetch_q;

  // room when empty or when the held item leaves this cycle
  assign o_fetch_ready = !valid_q || i_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
    end else if (o_fetch_ready) begin
      valid_q <= i_fetch_valid; // refill or drain
    end
  end

  // payload has no reset
  always_ff @(posedge i_clk) begin
    if (i_fetch_valid && o_fetch_ready) begin
      fetch_q <= i_fetch;
    end
  end

  assign o_valid = valid_q;
  assign o_fetch = fetch_q;

endmodule

//--- verilog/idu_imm_gen.sv
// Immediate generator
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_imm_gen (
  input  idu_pkg::inst_t    i_inst,
  input  idu_pkg::imm_fmt_e i_fmt,
  output idu_pkg::xlen_t    o_imm
);

  idu_pkg::xlen_t imm_i;
  idu_pkg::xlen_t imm_u;
  idu_pkg::xlen_t imm_s;
  idu_pkg::xlen_t imm_b;
  idu_pkg::xlen_t imm_j;

  assign imm_i = {{(`IDU_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`IDU_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(`IDU_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};

  // branch offset, bit 0 implied
  assign imm_b = {{(`IDU_XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};

  assign imm_j = {{(`IDU_XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    case (i_fmt)
      idu_pkg::IMM_I: o_imm = imm_i;
      idu_pkg::IMM_U: o_imm = imm_u;
      idu_pkg::IMM_S: o_imm = imm_s;
      idu_pkg::IMM_B: o_imm = imm_b;
      idu_pkg::IMM_J: o_imm = imm_j;
      default:        o_imm = '0; // r-type and unmatched
    endcase
  end

endmodule

//--- verilog/idu_ctrl_decode.sv
// Instruction control decoder
`timescale 1ns/1ps

module idu_ctrl_decode (
  input  idu_pkg::inst_t    i_inst,
  input  idu_pkg::xlen_t    i_imm,
  output idu_pkg::imm_fmt_e o_fmt,
  output idu_pkg::dec_ctrl_t o_ctrl
);

  idu_pkg::opcode_e  opcode;
  logic [2:0]        f3;
  logic [6:0]        f7;

  logic              match;
  logic              type_r;
  logic              is_load;
  logic              is_store;
  logic              is_branch;
  logic              is_jal;
  logic              is_jalr;
  logic              is_auipc;
  logic              word_op;
  idu_pkg::imm_fmt_e fmt;
  idu_pkg::alu_op_e  alu_op;
  idu_pkg::mem_op_e  mem_op;
  idu_pkg::br_func_e br_func;

  // integer ops shared by reg and imm forms
  function automatic idu_pkg::alu_op_e base_op(input logic [2:0] fn3, input logic alt);
    case (fn3)
      3'b000:  base_op = alt ? idu_pkg::ALU_SUB : idu_pkg::ALU_ADD;
      3'b001:  base_op = idu_pkg::ALU_SLL;
      3'b010:  base_op = idu_pkg::ALU_SLT;
      3'b011:  base_op = idu_pkg::ALU_SLTU;
      3'b100:  base_op = idu_pkg::ALU_XOR;
      3'b101:  base_op = alt ? idu_pkg::ALU_SRA : idu_pkg::ALU_SRL;
      3'b110:  base_op = idu_pkg::ALU_OR;
      default: base_op = idu_pkg::ALU_AND;
    endcase
  endfunction

  function automatic idu_pkg::alu_op_e muldiv_op(input logic [2:0] fn3);
    case (fn3)
      3'b000:  muldiv_op = idu_pkg::ALU_MUL;
      3'b001:  muldiv_op = idu_pkg::ALU_MULH;
      3'b010:  muldiv_op = idu_pkg::ALU_MULHSU;
      3'b011:  muldiv_op = idu_pkg::ALU_MULHU;
      3'b100:  muldiv_op = idu_pkg::ALU_DIV;
      3'b101:  muldiv_op = idu_pkg::ALU_DIVU;
      3'b110:  muldiv_op = idu_pkg::ALU_REM;
      default: muldiv_op = idu_pkg::ALU_REMU;
    endcase
  endfunction

  assign opcode = idu_pkg::opcode_e'(i_inst[6:0]);
  assign f3     = i_inst[14:12];
  assign f7     = i_inst[31:25];

  always_comb begin
    match     = 1'b0;
    type_r    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_auipc  = 1'b0;
    word_op   = 1'b0;
    fmt       = idu_pkg::IMM_NONE;
    alu_op    = idu_pkg::ALU_INVALID;
    mem_op    = idu_pkg::MEM_NONE;
    br_func   = idu_pkg::BR_JAL;
    case (opcode)
      idu_pkg::OPC_LUI: begin
        match  = 1'b1;
        fmt    = idu_pkg::IMM_U;
        alu_op = idu_pkg::ALU_COPY_IMM;
      end
      idu_pkg::OPC_AUIPC: begin
        match    = 1'b1;
        is_auipc = 1'b1;
        fmt      = idu_pkg::IMM_U;
        alu_op   = idu_pkg::ALU_ADD;
      end
      idu_pkg::OPC_JAL: begin
        match   = 1'b1;
        is_jal  = 1'b1;
        fmt     = idu_pkg::IMM_J;
        alu_op  = idu_pkg::ALU_ADD; // link pc + 4
        br_func = idu_pkg::BR_JAL;
      end
      idu_pkg::OPC_JALR: begin
        if (f3 == 3'b000) begin
          match   = 1'b1;
          is_jalr = 1'b1;
          fmt     = idu_pkg::IMM_I;
          alu_op  = idu_pkg::ALU_ADD;
          br_func = idu_pkg::BR_JALR;
        end
      end
      idu_pkg::OPC_BRANCH: begin
        if (f3[2:1] != 2'b01) begin
          match     = 1'b1;
          is_branch = 1'b1;
          fmt       = idu_pkg::IMM_B;
          alu_op    = idu_pkg::ALU_SUB; // compare rs1 - rs2
          br_func   = f3[2] ? idu_pkg::br_func_e'({1'b1, f3[1:0]})
                            : idu_pkg::br_func_e'({2'b01, f3[0]});
        end
      end
      idu_pkg::OPC_LOAD: begin
        if (f3 != 3'b111) begin
          match   = 1'b1;
          is_load = 1'b1;
          fmt     = idu_pkg::IMM_I;
          alu_op  = idu_pkg::ALU_ADD; // address calc
          case (f3)
            3'b000:  mem_op = idu_pkg::MEM_LB;
            3'b001:  mem_op = idu_pkg::MEM_LH;
            3'b010:  mem_op = idu_pkg::MEM_LW;
            3'b011:  mem_op = idu_pkg::MEM_LD;
            3'b100:  mem_op = idu_pkg::MEM_LBU;
            3'b101:  mem_op = idu_pkg::MEM_LHU;
            default: mem_op = idu_pkg::MEM_LWU;
          endcase
        end
      end
      idu_pkg::OPC_STORE: begin
        if (!f3[2]) begin
          match    = 1'b1;
          is_store = 1'b1;
          fmt      = idu_pkg::IMM_S;
          alu_op   = idu_pkg::ALU_ADD;
          case (f3[1:0])
            2'b00:   mem_op = idu_pkg::MEM_LB;
            2'b01:   mem_op = idu_pkg::MEM_LH;
            2'b10:   mem_op = idu_pkg::MEM_LW;
            default: mem_op = idu_pkg::MEM_LD;
          endcase
        end
      end
      idu_pkg::OPC_OP_IMM: begin
        // 64-bit shamt leaves only f7[6:1] as function bits
        if ((f3 != 3'b001 && f3 != 3'b101) || f7[6:1] == 6'b000000 ||
            (f3 == 3'b101 && f7[6:1] == 6'b010000)) begin
          match  = 1'b1;
          fmt    = idu_pkg::IMM_I;
          alu_op = base_op(f3, f3 == 3'b101 && f7[5]);
        end
      end
      idu_pkg::OPC_OP_IMM_32: begin
        if (f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'b0000000) ||
            (f3 == 3'b101 && (f7 == 7'b0000000 || f7 == 7'b0100000))) begin
          match   = 1'b1;
          word_op = 1'b1;
          fmt     = idu_pkg::IMM_I;
          alu_op  = base_op(f3, f3 == 3'b101 && f7[5]);
        end
      end
      idu_pkg::OPC_OP: begin
        if (f7 == 7'b0000001) begin
          match  = 1'b1;
          type_r = 1'b1;
          alu_op = muldiv_op(f3);
        end else if (f7 == 7'b0000000 ||
                     (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))) begin
          match  = 1'b1;
          type_r = 1'b1;
          alu_op = base_op(f3, f7[5]);
        end
      end
      idu_pkg::OPC_OP_32: begin
        if (f7 == 7'b0000001 && (f3 == 3'b000 || f3[2])) begin
          match   = 1'b1;
          type_r  = 1'b1;
          word_op = 1'b1;
          alu_op  = muldiv_op(f3);
        end else if ((f7 == 7'b0000000 && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) ||
                     (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))) begin
          match   = 1'b1;
          type_r  = 1'b1;
          word_op = 1'b1;
          alu_op  = base_op(f3, f7[5]);
        end
      end
      default: begin
        match = 1'b0; // system opcode lands here too
      end
    endcase
  end

  assign o_fmt = fmt;

  always_comb begin
    o_ctrl            = '0;
    o_ctrl.rd         = i_inst[11:7];
    o_ctrl.imm        = i_imm;
    o_ctrl.alu_a_src  = is_jal || is_jalr || is_auipc;
    if (is_jal || is_jalr) begin
      o_ctrl.alu_b_src = idu_pkg::ALU_B_FOUR;
    end else if (fmt == idu_pkg::IMM_I || fmt == idu_pkg::IMM_U || fmt == idu_pkg::IMM_S) begin
      o_ctrl.alu_b_src = idu_pkg::ALU_B_IMM;
    end else begin
      o_ctrl.alu_b_src = idu_pkg::ALU_B_RS2;
    end
    o_ctrl.alu_op     = alu_op;
    o_ctrl.word_cut   = word_op;
    o_ctrl.reg_wr     = type_r || fmt == idu_pkg::IMM_I || fmt == idu_pkg::IMM_U ||
                        fmt == idu_pkg::IMM_J;
    o_ctrl.mem_to_reg = is_load;
    o_ctrl.mem_wr     = is_store;
    o_ctrl.mem_re     = is_load;
    o_ctrl.mem_op     = mem_op;
    o_ctrl.br_en      = is_branch || is_jal || is_jalr;
    o_ctrl.br_func    = br_func;
    o_ctrl.invalid    = !match && (i_inst != '0); // all-zero word is a bubble
  end

endmodule

//--- verilog/idu_gpr_file.sv
// General register file
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_gpr_file (
  input  logic               i_clk,
  input  idu_pkg::reg_addr_t i_raddr1,
  input  idu_pkg::reg_addr_t i_raddr2,
  output idu_pkg::xlen_t     o_rdata1,
  output idu_pkg::xlen_t     o_rdata2,
  input  idu_pkg::wb_t       i_wb
);

  idu_pkg::xlen_t regs [`IDU_NUM_REGS];

  // x0 never written
  always_ff @(posedge i_clk) begin
    if (i_wb.wen && i_wb.waddr != '0) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // async reads, no bypass of the write port
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- verilog/idu_top.sv
// Instruction decode stage
`timescale 1ns/1ps

module idu_top (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_fetch_valid,
  input  idu_pkg::fetch_t     i_fetch,
  output logic                o_fetch_ready,
  output logic                o_dec_valid,
  input  logic                i_dec_ready,
  output idu_pkg::dec_ctrl_t  o_dec,
  output idu_pkg::xlen_t      o_pc,
  output idu_pkg::xlen_t      o_rs1_data,
  output idu_pkg::xlen_t      o_rs2_data,
  input  idu_pkg::wb_t        i_wb
);

  idu_pkg::fetch_t   held;
  idu_pkg::imm_fmt_e imm_fmt;
  idu_pkg::xlen_t    imm;

  idu_inst_reg inst_reg_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_fetch_valid (i_fetch_valid),
    .i_fetch       (i_fetch),
    .o_fetch_ready (o_fetch_ready),
    .o_valid       (o_dec_valid),
    .i_ready       (i_dec_ready),
    .o_fetch       (held)
  );

  idu_ctrl_decode ctrl_decode_inst (
    .i_inst (held.inst),
    .i_imm  (imm),
    .o_fmt  (imm_fmt),
    .o_ctrl (o_dec)
  );

  idu_imm_gen imm_gen_inst (
    .i_inst (held.inst),
    .i_fmt  (imm_fmt),
    .o_imm  (imm)
  );

  // rs1 and rs2 fields
  idu_gpr_file gpr_file_inst (
    .i_clk    (i_clk),
    .i_raddr1 (held.inst[19:15]),
    .i_raddr2 (held.inst[24:20]),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data),
    .i_wb     (i_wb)
  );

  assign o_pc = held.pc;

endmodule

//--- tb/tb_idu.sv
// Decode stage testbench
`timescale 1ns/1ps

module tb_idu;

  localparam int N_RECS    = 24;
  localparam int REC_WORDS = 19;
  localparam int CLK_NS    = 4;

  logic               i_clk;
  logic               i_reset;
  logic               i_fetch_valid;
  idu_pkg::fetch_t    i_fetch;
  logic               o_fetch_ready;
  logic               o_dec_valid;
  logic               i_dec_ready;
  idu_pkg::dec_ctrl_t o_dec;
  idu_pkg::xlen_t     o_pc;
  idu_pkg::xlen_t     o_rs1_data;
  idu_pkg::xlen_t     o_rs2_data;
  idu_pkg::wb_t       i_wb;

  logic [63:0] vec_mem [0:N_RECS*REC_WORDS-1];
  integer      seed;

  idu_pkg::fetch_t    fetch_list [$]; // decode records in file order
  idu_pkg::dec_ctrl_t exp_ctrl [$];
  idu_pkg::xlen_t     exp_rs1 [$];
  idu_pkg::xlen_t     exp_rs2 [$];

  idu_top idu_top_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_fetch_valid (i_fetch_valid),
    .i_fetch       (i_fetch),
    .o_fetch_ready (o_fetch_ready),
    .o_dec_valid   (o_dec_valid),
    .i_dec_ready   (i_dec_ready),
    .o_dec         (o_dec),
    .o_pc          (o_pc),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .i_wb          (i_wb)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_NS/2) i_clk = ~i_clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_ctrl(input idu_pkg::dec_ctrl_t got, input idu_pkg::dec_ctrl_t exp,
                            input string name);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t ns: %s got %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_data(input idu_pkg::xlen_t got, input idu_pkg::xlen_t exp,
                            input string name);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t ns: %s got %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t ns: %s got %b, expected %b",
                              $time, name, got, exp));
    end
  endtask

  function automatic idu_pkg::dec_ctrl_t ctrl_from_record(input int base);
    idu_pkg::dec_ctrl_t c;
    c.rd         = vec_mem[base+3][4:0];
    c.imm        = vec_mem[base+4];
    c.alu_a_src  = vec_mem[base+5][0];
    c.alu_b_src  = idu_pkg::alu_b_src_e'(vec_mem[base+6][1:0]);
    c.alu_op     = idu_pkg::alu_op_e'(vec_mem[base+7][4:0]);
    c.word_cut   = vec_mem[base+8][0];
    c.reg_wr     = vec_mem[base+9][0];
    c.mem_to_reg = vec_mem[base+10][0];
    c.mem_wr     = vec_mem[base+11][0];
    c.mem_re     = vec_mem[base+12][0];
    c.mem_op     = idu_pkg::mem_op_e'(vec_mem[base+13][2:0]);
    c.br_en      = vec_mem[base+14][0];
    c.br_func    = idu_pkg::br_func_e'(vec_mem[base+15][2:0]);
    c.invalid    = vec_mem[base+16][0];
    return c;
  endfunction

  task automatic write_reg(input idu_pkg::reg_addr_t addr, input idu_pkg::xlen_t data);
    @(posedge i_clk);
    #1;
    i_wb.wen   = 1'b1;
    i_wb.waddr = addr;
    i_wb.wdata = data;
    @(posedge i_clk);
    #1;
    i_wb.wen   = 1'b0;
  endtask

  // streams every decode record, outputs sampled at the falling edge
  task automatic run_decodes(input logic rand_ready);
    int                 sent;
    int                 got;
    int                 r;
    logic               took;
    logic               stalled;
    idu_pkg::dec_ctrl_t prev_dec;
    idu_pkg::xlen_t     prev_pc;
    sent    = 0;
    got     = 0;
    took    = 1'b0;
    stalled = 1'b0;
    while (got < fetch_list.size()) begin
      @(posedge i_clk);
      #1;
      r             = $random(seed);
      i_dec_ready   = rand_ready ? r[0] : 1'b1;
      i_fetch_valid = (sent < fetch_list.size());
      if (sent < fetch_list.size()) begin
        i_fetch = fetch_list[sent]; // held until accepted
      end
      @(negedge i_clk);
      if (took) begin
        check_flag(o_dec_valid, 1'b1, "o_dec_valid one cycle after fetch");
        if (got != sent - 1) begin
          stop_on_error("The decode result of a fetch did not appear one cycle after it");
        end
      end
      if (stalled) begin
        check_flag(o_dec_valid, 1'b1, "o_dec_valid under back-pressure");
        check_ctrl(o_dec, prev_dec, "o_dec under back-pressure");
        check_data(o_pc, prev_pc, "o_pc under back-pressure");
      end
      if (o_dec_valid && !i_dec_ready) begin
        check_flag(o_fetch_ready, 1'b0, "o_fetch_ready while full and stalled");
      end
      if (!rand_ready && i_fetch_valid) begin
        check_flag(o_fetch_ready, 1'b1, "o_fetch_ready with i_dec_ready high");
      end
      if (o_dec_valid && i_dec_ready) begin
        if (got >= sent) begin
          stop_on_error("Decode output was handed over without a matching fetch");
        end
        check_ctrl(o_dec, exp_ctrl[got], "o_dec");
        check_data(o_pc, fetch_list[got].pc, "o_pc");
        check_data(o_rs1_data, exp_rs1[got], "o_rs1_data");
        check_data(o_rs2_data, exp_rs2[got], "o_rs2_data");
        got++;
      end
      stalled  = o_dec_valid && !i_dec_ready;
      prev_dec = o_dec;
      prev_pc  = o_pc;
      took     = i_fetch_valid && o_fetch_ready;
      if (took) begin
        sent++;
      end
    end
    @(posedge i_clk);
    #1;
    i_fetch_valid = 1'b0;
    i_dec_ready   = 1'b0;
  endtask

  initial begin
    int              base;
    idu_pkg::fetch_t f;
    seed          = 51904;
    i_reset       = 1'b1;
    i_fetch_valid = 1'b0;
    i_fetch       = '0;
    i_dec_ready   = 1'b0;
    i_wb          = '0;
    $readmemh("tb/idu_vectors.txt", vec_mem);
    fork
      begin
        #(N_RECS * 20 * CLK_NS);
        $display("Timeout: the decode stage stopped responding at %0t ns", $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
      end
    join_none
    repeat (2) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    @(negedge i_clk);
    check_flag(o_dec_valid, 1'b0, "o_dec_valid after reset");
    check_flag(o_fetch_ready, 1'b1, "o_fetch_ready after reset");
    for (int n = 0; n < N_RECS; n++) begin
      base = n * REC_WORDS;
      if (vec_mem[base] == 64'h1) begin
        write_reg(vec_mem[base+2][4:0], vec_mem[base+17]);
      end else if (vec_mem[base] == 64'hd) begin
        f.inst = vec_mem[base+1][31:0];
        f.pc   = vec_mem[base+2];
        fetch_list.push_back(f);
        exp_ctrl.push_back(ctrl_from_record(base));
        exp_rs1.push_back(vec_mem[base+17]);
        exp_rs2.push_back(vec_mem[base+18]);
      end else begin
        stop_on_error($sformatf("Vector record %0d has an unknown kind", n));
      end
    end
    run_decodes(1'b1); // random back-pressure
    run_decodes(1'b0); // full throughput
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/idu_pkg.sv
verilog/idu_inst_reg.sv
verilog/idu_imm_gen.sv
verilog/idu_ctrl_decode.sv
verilog/idu_gpr_file.sv
verilog/idu_top.sv
tb/tb_idu.sv

//--- tb/idu_vectors.txt
// kind(1 reg write, d decode) inst pc rd imm a_src b_src alu_op wcut reg_wr mem_to_reg mem_wr
// mem_re mem_op br_en br_func invalid rs1 rs2 (writes use pc as index, rs1 as data)
1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 123456789abcdef0 0
1 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fedcba9876543210 0
1 0 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 33 0
1 0 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 ffffffffffffffc4 0
1 0 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 55555555 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 deadbeef 0
d 00208333 80000000 06 0 0 0 00 0 1 0 0 0 7 0 0 0 123456789abcdef0 fedcba9876543210
d 404183b3 80000004 07 0 0 0 01 0 1 0 0 0 7 0 0 0 33 ffffffffffffffc4
d 0002e433 80000008 08 0 0 0 06 0 1 0 0 0 7 0 0 0 55555555 0
d fe008493 8000000c 09 ffffffffffffffe0 0 1 00 0 1 0 0 0 7 0 0 0 123456789abcdef0 0
d aa20d537 80000010 0a ffffffffaa20d000 0 1 0f 0 1 0 0 0 7 0 0 0 123456789abcdef0 fedcba9876543210
d 00318597 80000014 0b 318000 1 1 00 0 1 0 0 0 7 0 0 0 33 33
d 0022aa23 80000018 14 14 0 1 00 0 0 0 1 0 4 0 0 0 55555555 fedcba9876543210
d fe2088e3 8000001c 11 fffffffffffffff0 0 0 01 0 0 0 0 0 7 1 2 0 123456789abcdef0 fedcba9876543210
d 100000ef 80000020 01 100 1 2 00 0 1 0 0 0 7 1 0 0 0 0
d 040202e7 80000024 05 40 1 2 00 0 1 0 0 0 7 1 1 0 ffffffffffffffc4 0
d fc013603 80000028 0c ffffffffffffffc0 0 1 00 0 1 1 0 1 6 0 0 0 fedcba9876543210 0
d 0031c683 8000002c 0d 3 0 1 00 0 1 1 0 1 1 0 0 0 33 33
d 0052073b 80000030 0e 0 0 0 00 1 1 0 0 0 7 0 0 0 ffffffffffffffc4 55555555
d 022097b3 80000034 0f 0 0 0 19 0 1 0 0 0 7 0 0 0 123456789abcdef0 fedcba9876543210
d 0241d833 80000038 10 0 0 0 0c 0 1 0 0 0 7 0 0 0 33 ffffffffffffffc4
d 00000073 8000003c 00 0 0 0 1f 0 0 0 0 0 7 0 0 1 0 0
d 0020807f 80000040 00 0 0 0 1f 0 0 0 0 0 7 0 0 1 123456789abcdef0 fedcba9876543210
d 00000000 80000044 00 0 0 0 1f 0 0 0 0 0 7 0 0 0 0 0
